// ==== verilog/sd_host_config.svh ====
// SD host configuration: register map, buffer geometry and controller status bits
`ifndef SD_HOST_CONFIG_SVH
`define SD_HOST_CONFIG_SVH

// ==============================
// Buffer geometry
// ==============================
`define SD_BUF_DEPTH    256         // 16-bit words in the sector buffer
`define SD_SECTOR_BYTES 512         // Bytes moved per transfer

// ==============================
// APB register map (word offsets)
// ==============================
`define REG_CMD    2'd0             // Bit 0 read card, bit 1 write card
`define REG_LBA_HI 2'd1             // Block address 23:16 in bits 7:0
`define REG_LBA_LO 2'd2             // Block address 15:0
`define REG_STATUS 2'd3             // Busy and last controller status
`define BUF_BASE   12'h200          // Buffer window, byte offset

// ==============================
// SD controller register port
// ==============================
`define SDC_DATA 3'd0               // Data byte in/out
`define SDC_CTRL 3'd1               // Status read, start write
`define SDC_LBA0 3'd2               // Address bytes at 2, 3 and 4

// Controller status bit positions
`define ST_TX_EMPTY   7
`define ST_RX_READY   6
`define ST_BLOCK_BUSY 5
`define ST_INIT_BUSY  4

`endif

// ==== verilog/sd_host_pkg.sv ====
// SD host types: data vectors, bus structs and the sequencer state encoding
package sd_host_pkg;

    // ==============================
    // Vector types
    // ==============================
    typedef logic [15:0] word_t;        // Buffer and APB data word
    typedef logic [7:0]  sdc_byte_t;    // Controller data or status byte
    typedef logic [23:0] lba_t;         // SDHC block address
    typedef logic [7:0]  buf_addr_t;    // Buffer word index
    typedef logic [2:0]  sdc_reg_t;     // Controller register select

    // APB request, master to slave
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        word_t       pwdata;
        logic [1:0]  pstrb;             // Bit 1 is the high byte
    } apb_req_t;

    // APB response, slave to master
    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    // One buffer access
    typedef struct packed {
        logic      en;
        logic      we;
        logic [1:0] be;
        buf_addr_t addr;
        word_t     wdata;
    } buf_port_t;

    // Toward the SD controller register port
    typedef struct packed {
        sdc_reg_t  addr;
        sdc_byte_t wdata;
        logic      wr;                  // One-cycle pulse
        logic      rd;                  // One-cycle pulse
    } sdc_req_t;

    // Register bank to sequencer
    typedef struct packed {
        logic start;
        logic dir;                      // 0 read card, 1 write card
        lba_t lba;
    } xfer_cmd_t;

    typedef enum logic [3:0] {
        IDLE, ADDR_SET, ADDR_STROBE, ADDR_NEXT, WAIT_READY, POLL,
        RD_STROBE, RD_STORE, WR_FETCH, WR_STROBE, DONE
    } seq_state_t;

endpackage

// ==== verilog/sd_host_regs.sv ====
// SD host register bank: APB slave with command, block address, status and buffer window
`timescale 1ns/1ns
`include "sd_host_config.svh"

module sd_host_regs import sd_host_pkg::*; (
    input  logic      rst,              // Clock
    input  logic      clk,              // Async reset, active high
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    output xfer_cmd_t xfer,
    input  logic      busy,
    input  sdc_byte_t last_status,
    output buf_port_t buf_a,
    input  word_t     buf_rdata
);

    localparam logic [11:0] BUF_BASE_ADDR = `BUF_BASE;

    word_t cmd_q;                       // Last accepted command
    lba_t  lba_q;
    logic  start_q;
    logic  rd_wait_q;                   // Buffer read data arrives this cycle

    logic  access;
    logic  buf_hit;
    logic  reg_hit;
    logic  buf_rd_first;
    logic  buf_wr_ok;
    logic  cmd_ok;
    logic [1:0] reg_idx;

    // ==============================
    // Address decode
    // ==============================
    assign access  = apb_req.psel & apb_req.penable;
    assign buf_hit = (apb_req.paddr[11:9] == BUF_BASE_ADDR[11:9]);   // 0x200 to 0x3FF
    assign reg_hit = (apb_req.paddr[11:3] == 9'd0);
    assign reg_idx = apb_req.paddr[2:1];

    // First access cycle of a buffer read, RAM gets the address now
    assign buf_rd_first = access & buf_hit & ~apb_req.pwrite & ~busy & ~rd_wait_q;
    assign buf_wr_ok    = access & buf_hit & apb_req.pwrite & ~busy;

    // Exactly one direction bit, and only while idle
    assign cmd_ok = access & reg_hit & apb_req.pwrite & (reg_idx == `REG_CMD) & ~busy
                  & (apb_req.pwdata[0] ^ apb_req.pwdata[1]);

    // ==============================
    // Control registers
    // ==============================
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            cmd_q     <= '0;
            lba_q     <= '0;
            start_q   <= 1'b0;
            rd_wait_q <= 1'b0;
        end else begin
            start_q   <= cmd_ok;            // One-cycle pulse
            rd_wait_q <= buf_rd_first;
            if (cmd_ok) cmd_q <= apb_req.pwdata;
            if (access && reg_hit && apb_req.pwrite) begin
                case (reg_idx)
                    `REG_LBA_HI: lba_q[23:16] <= apb_req.pwdata[7:0];
                    `REG_LBA_LO: lba_q[15:0]  <= apb_req.pwdata;
                    default: ;              // CMD handled above, STATUS is read only
                endcase
            end
        end
    end

    assign xfer.start = start_q;
    assign xfer.dir   = cmd_q[1];
    assign xfer.lba   = lba_q;

    // ==============================
    // Buffer port A
    // ==============================
    always_comb begin
        buf_a.en    = buf_rd_first | buf_wr_ok;
        buf_a.we    = apb_req.pwrite;
        buf_a.be    = apb_req.pwrite ? apb_req.pstrb : 2'b11;
        buf_a.addr  = apb_req.paddr[8:1];
        buf_a.wdata = apb_req.pwdata;
    end

    // ==============================
    // APB response
    // ==============================
    always_comb begin
        apb_rsp.pready  = ~buf_rd_first;                        // Single read wait state
        apb_rsp.pslverr = access & buf_hit & busy & ~rd_wait_q; // Buffer owned by sequencer
        apb_rsp.prdata  = '0;
        if (buf_hit) begin
            apb_rsp.prdata = buf_rdata;
        end else if (reg_hit) begin
            case (reg_idx)
                `REG_CMD:    apb_rsp.prdata = cmd_q;
                `REG_LBA_HI: apb_rsp.prdata = {8'h00, lba_q[23:16]};
                `REG_LBA_LO: apb_rsp.prdata = lba_q[15:0];
                `REG_STATUS: apb_rsp.prdata = {last_status, 7'b0, busy};
                default:     apb_rsp.prdata = '0;
            endcase
        end
    end

    // Access phase only follows a selected setup phase
    a_penable_psel: assert property (@(posedge rst) disable iff (clk)
        apb_req.penable |-> apb_req.psel);

endmodule

// ==== verilog/sector_buffer.sv ====
// Sector buffer: 256 x 16 RAM with byte enables, owned by APB or the sequencer
`timescale 1ns/1ns
`include "sd_host_config.svh"

module sector_buffer import sd_host_pkg::*; (
    input  logic      rst,              // Clock
    input  logic      clk,              // Async reset, active high
    input  logic      busy,             // Sequencer owns the RAM
    input  buf_port_t buf_a,            // APB side
    input  buf_port_t buf_b,            // Sequencer side
    output word_t     rdata
);

    word_t     mem [0:`SD_BUF_DEPTH-1];
    buf_port_t port;

    // Owner select, one port reaches the RAM at a time
    assign port = busy ? buf_b : buf_a;

    // ==============================
    // RAM array
    // ==============================
    always_ff @(posedge rst) begin
        if (port.en) begin
            if (port.we) begin
                if (port.be[1]) mem[port.addr][15:8] <= port.wdata[15:8];   // Even byte
                if (port.be[0]) mem[port.addr][7:0]  <= port.wdata[7:0];    // Odd byte
            end
            rdata <= mem[port.addr];    // Old data on a write, held until next enable
        end
    end

    // Sequencer side only works during a transfer
    a_port_b_owner: assert property (@(posedge rst) disable iff (clk)
        buf_b.en |-> busy);

endmodule

// ==== verilog/sd_block_seq.sv ====
// SD block sequencer: address phase and 512-byte stream over the controller register port
`timescale 1ns/1ns
`include "sd_host_config.svh"

module sd_block_seq import sd_host_pkg::*; (
    input  logic      rst,              // Clock
    input  logic      clk,              // Async reset, active high
    input  xfer_cmd_t xfer,
    output logic      busy,
    output sdc_byte_t last_status,
    output buf_port_t buf_b,
    input  word_t     buf_rdata,
    output sdc_req_t  sdc_req,
    input  sdc_byte_t sdc_rdata
);

    seq_state_t state;
    logic [1:0] addr_cnt;               // Four address-phase steps
    logic [9:0] byte_cnt;               // Saturates at 512
    sdc_reg_t   sdc_addr_q;
    sdc_byte_t  sdc_wdata_q;

    lba_t       lba_q;                  // Latched at start
    logic       dir_q;
    sdc_byte_t  data_q;                 // Byte taken on the rd strobe
    sdc_byte_t  hi_byte;                // Even byte waiting for its partner

    logic       in_range;
    sdc_byte_t  wr_byte;

    assign in_range = (byte_cnt < `SD_SECTOR_BYTES);

    // Fetched word stays on buf_rdata for both bytes
    assign wr_byte = !in_range   ? 8'h00 :
                     byte_cnt[0] ? buf_rdata[7:0] : buf_rdata[15:8];

    // ==============================
    // Controller port
    // ==============================
    always_comb begin
        sdc_req.addr  = sdc_addr_q;
        sdc_req.wdata = (state == WR_STROBE) ? wr_byte : sdc_wdata_q;
        sdc_req.wr    = (state == ADDR_STROBE) || (state == WR_STROBE);
        sdc_req.rd    = (state == RD_STROBE);
    end

    // ==============================
    // Buffer port B
    // ==============================
    always_comb begin
        buf_b.en    = (state == RD_STORE && in_range && byte_cnt[0])   // Odd byte completes word
                    || (state == WR_FETCH && in_range && !byte_cnt[0]); // One fetch per word
        buf_b.we    = (state == RD_STORE);
        buf_b.be    = 2'b11;
        buf_b.addr  = byte_cnt[8:1];
        buf_b.wdata = {hi_byte, data_q};
    end

    // Data path
    always_ff @(posedge rst) begin
        if (state == IDLE && xfer.start) begin
            lba_q <= xfer.lba;
            dir_q <= xfer.dir;
        end
        if (state == RD_STROBE) data_q <= sdc_rdata;
        if (state == RD_STORE && !byte_cnt[0]) hi_byte <= data_q;
    end

    // ==============================
    // Sequencer FSM
    // ==============================
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state       <= IDLE;
            busy        <= 1'b0;
            addr_cnt    <= '0;
            byte_cnt    <= '0;
            sdc_addr_q  <= `SDC_CTRL;
            sdc_wdata_q <= '0;
            last_status <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (xfer.start) begin
                        addr_cnt <= '0;
                        busy     <= 1'b1;
                        state    <= ADDR_SET;
                    end
                end
                // Address bytes 7:0, 15:8, 23:16 then the direction byte
                ADDR_SET: begin
                    if (addr_cnt == 2'd3) begin
                        sdc_addr_q  <= `SDC_CTRL;
                        sdc_wdata_q <= {7'b0, dir_q};
                    end else begin
                        sdc_addr_q  <= sdc_reg_t'(`SDC_LBA0 + addr_cnt);
                        sdc_wdata_q <= lba_q[addr_cnt*8 +: 8];
                    end
                    state <= ADDR_STROBE;
                end
                ADDR_STROBE: state <= ADDR_NEXT;    // wr high this cycle
                ADDR_NEXT: begin
                    addr_cnt <= addr_cnt + 2'd1;
                    if (addr_cnt == 2'd3) begin
                        sdc_addr_q <= `SDC_CTRL;
                        byte_cnt   <= '0;
                        state      <= WAIT_READY;
                    end else begin
                        state <= ADDR_SET;
                    end
                end
                // Card initialized and block accepted
                WAIT_READY: begin
                    last_status <= sdc_rdata;
                    if (!sdc_rdata[`ST_INIT_BUSY] && sdc_rdata[`ST_BLOCK_BUSY])
                        state <= POLL;
                end
                POLL: begin
                    last_status <= sdc_rdata;
                    if (!sdc_rdata[`ST_BLOCK_BUSY]) begin
                        state <= DONE;              // Block finished
                    end else if (!dir_q && sdc_rdata[`ST_RX_READY]) begin
                        sdc_addr_q <= `SDC_DATA;
                        state      <= RD_STROBE;
                    end else if (dir_q && sdc_rdata[`ST_TX_EMPTY]) begin
                        sdc_addr_q <= `SDC_DATA;
                        state      <= WR_FETCH;
                    end
                end
                RD_STROBE: begin
                    sdc_addr_q <= `SDC_CTRL;
                    state      <= RD_STORE;
                end
                RD_STORE: begin
                    if (in_range) byte_cnt <= byte_cnt + 10'd1;   // Extra bytes dropped
                    state <= POLL;
                end
                WR_FETCH: state <= WR_STROBE;       // RAM read in flight
                WR_STROBE: begin
                    sdc_addr_q <= `SDC_CTRL;
                    if (in_range) byte_cnt <= byte_cnt + 10'd1;
                    state <= POLL;
                end
                DONE: begin
                    busy  <= 1'b0;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // One strobe per controller cycle
    a_no_wr_rd: assert property (@(posedge rst) disable iff (clk)
        !(sdc_req.wr && sdc_req.rd));

endmodule

// ==== verilog/sd_host_top.sv ====
// SD host top: register bank, sector buffer and block sequencer
`timescale 1ns/1ns

module sd_host_top import sd_host_pkg::*; (
    input  logic      rst,              // Clock
    input  logic      clk,              // Async reset, active high
    input  apb_req_t  apb_req,
    output apb_rsp_t  apb_rsp,
    output sdc_req_t  sdc_req,
    input  sdc_byte_t sdc_rdata
);

    xfer_cmd_t xfer;
    logic      busy;
    sdc_byte_t last_status;
    buf_port_t buf_a;                   // APB side
    buf_port_t buf_b;                   // Sequencer side
    word_t     buf_rdata;

    sd_host_regs u_regs (
        .rst         (rst),
        .clk         (clk),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .xfer        (xfer),
        .busy        (busy),
        .last_status (last_status),
        .buf_a       (buf_a),
        .buf_rdata   (buf_rdata)
    );

    sector_buffer u_buf (
        .rst   (rst),
        .clk   (clk),
        .busy  (busy),
        .buf_a (buf_a),
        .buf_b (buf_b),
        .rdata (buf_rdata)
    );

    sd_block_seq u_seq (
        .rst         (rst),
        .clk         (clk),
        .xfer        (xfer),
        .busy        (busy),
        .last_status (last_status),
        .buf_b       (buf_b),
        .buf_rdata   (buf_rdata),
        .sdc_req     (sdc_req),
        .sdc_rdata   (sdc_rdata)
    );

endmodule

// ==== tests/sd_card_model.sv ====
// SD controller model: byte register port with a sector store, status flags and a write record
`timescale 1ns/1ns
`include "sd_host_config.svh"

module sd_card_model import sd_host_pkg::*; (
    input  logic      rst,              // Clock
    input  logic      clk,              // Async reset, active high
    input  sdc_req_t  sdc_req,
    output sdc_byte_t sdc_rdata
);

    localparam logic [1:0] GAP = 2'd2;  // Idle cycles between bytes

    sdc_byte_t  sector_mem [0:`SD_SECTOR_BYTES-1];  // Card contents, loaded by the testbench
    sdc_byte_t  wr_record  [0:`SD_SECTOR_BYTES-1];  // Bytes received during a write block
    sdc_byte_t  lba_regs   [0:2];
    logic       dir;                    // High while a write block runs
    logic       block_busy;
    logic [3:0] init_cnt;
    logic [1:0] gap_cnt;                // Throttles the byte stream
    logic [9:0] idx;                    // Byte position in the block
    logic       byte_go;                // Data strobe accepted
    sdc_byte_t  status;
    sdc_byte_t  data_byte;

    assign byte_go = block_busy && (sdc_req.addr == `SDC_DATA)
                   && ((dir && sdc_req.wr) || (!dir && sdc_req.rd));
    assign data_byte = (idx < 10'd512) ? sector_mem[idx[8:0]] : 8'hFF;

    // ==============================
    // Status byte and read port
    // ==============================
    always_comb begin
        status = 8'h00;
        status[`ST_INIT_BUSY]  = (init_cnt != 4'd0);
        status[`ST_BLOCK_BUSY] = block_busy;
        status[`ST_RX_READY]   = block_busy && !dir && gap_cnt == 2'd0 && init_cnt == 4'd0;
        status[`ST_TX_EMPTY]   = block_busy && dir && gap_cnt == 2'd0 && init_cnt == 4'd0;
    end

    always_comb begin
        case (sdc_req.addr)             // Same-cycle read
            `SDC_DATA: sdc_rdata = data_byte;
            `SDC_CTRL: sdc_rdata = status;
            3'd2:      sdc_rdata = lba_regs[0];
            3'd3:      sdc_rdata = lba_regs[1];
            3'd4:      sdc_rdata = lba_regs[2];
            default:   sdc_rdata = 8'h00;
        endcase
    end

    // ==============================
    // Block state
    // ==============================
    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            dir        <= 1'b0;
            block_busy <= 1'b0;
            init_cnt   <= 4'd8;         // Card init after power-up
            gap_cnt    <= 2'd0;
            idx        <= '0;
        end else begin
            if (init_cnt != 4'd0) init_cnt <= init_cnt - 4'd1;
            if (gap_cnt != 2'd0) gap_cnt <= gap_cnt - 2'd1;
            if (sdc_req.wr && sdc_req.addr == `SDC_CTRL) begin
                dir        <= sdc_req.wdata[0];
                block_busy <= 1'b1;
                init_cnt   <= 4'd3;     // Short init pause per block
                gap_cnt    <= GAP;
                idx        <= '0;
            end else if (byte_go) begin
                gap_cnt <= GAP;
                idx     <= idx + 10'd1;
                if (idx == 10'd511) block_busy <= 1'b0;   // Last byte ends the block
            end
        end
    end

    always_ff @(posedge rst) begin
        if (sdc_req.wr && sdc_req.addr >= `SDC_LBA0 && sdc_req.addr <= `SDC_LBA0 + 3'd2)
            lba_regs[sdc_req.addr - `SDC_LBA0] <= sdc_req.wdata;
        if (byte_go && dir)
            wr_record[idx[8:0]] <= sdc_req.wdata;
    end

endmodule

// ==== tests/tb_sd_host.sv ====
// SD host testbench: APB stimulus, card model, sector reference pattern and result checks
`timescale 1ns/1ns
`include "sd_host_config.svh"

module tb_sd_host import sd_host_pkg::*; ();

    localparam int WAIT_LIMIT = 64;     // Cycles per APB transfer
    localparam int POLL_LIMIT = 4000;   // Status reads per block
    localparam logic [11:0] A_CMD    = 12'(`REG_CMD) << 1;
    localparam logic [11:0] A_LBA_HI = 12'(`REG_LBA_HI) << 1;
    localparam logic [11:0] A_LBA_LO = 12'(`REG_LBA_LO) << 1;
    localparam logic [11:0] A_STATUS = 12'(`REG_STATUS) << 1;

    typedef struct {
        string       name;
        logic [31:0] act;
        logic [31:0] want;
    } check_t;

    logic        rst = 1'b0;            // Clock
    logic        clk;                   // Reset
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    sdc_req_t    sdc_req;
    sdc_byte_t   sdc_rdata;
    int          seed = 86;
    int          errors = 0;
    int          timeouts = 0;
    int          checks = 0;
    check_t      chk_q [$];
    logic [10:0] addr_log [$];          // {register, byte} of controller setup writes

    always #2 rst = ~rst;

    sd_host_top u_dut (
        .rst       (rst),
        .clk       (clk),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .sdc_req   (sdc_req),
        .sdc_rdata (sdc_rdata)
    );

    sd_card_model u_card (
        .rst       (rst),
        .clk       (clk),
        .sdc_req   (sdc_req),
        .sdc_rdata (sdc_rdata)
    );

    // ==============================
    // Reference model
    // ==============================
    // Card byte at idx of block lba, every address bit matters
    function automatic sdc_byte_t pattern_byte(input lba_t lba, input int idx);
        logic [8:0] i;
        i = idx[8:0];
        return sdc_byte_t'(i[7:0] * 8'd37) ^ {i[8], 7'h2B} ^ lba[7:0] ^ lba[15:8]
             ^ (lba[23:16] + 8'h5A);
    endfunction

    function automatic word_t merge_word(input word_t old, input word_t wdata,
                                         input logic [1:0] strb);
        word_t w;
        w = old;
        if (strb[1]) w[15:8] = wdata[15:8];    // Even byte
        if (strb[0]) w[7:0] = wdata[7:0];
        return w;
    endfunction

    function automatic logic [11:0] buf_addr(input int w);
        return `BUF_BASE + 12'(w * 2);
    endfunction

    // ==============================
    // Checking and run control
    // ==============================
    task automatic queue_check(input string name, input logic [31:0] act,
                               input logic [31:0] want);
        check_t c;
        c.name = name;
        c.act  = act;
        c.want = want;
        chk_q.push_back(c);
    endtask

    always @(posedge rst) begin : compare
        check_t c;
        while (chk_q.size() > 0) begin
            c = chk_q.pop_front();
            checks++;
            assert (c.act === c.want) else begin
                errors++;
                $display("[FAIL] %s: got 0x%0h, expected 0x%0h", c.name, c.act, c.want);
            end
        end
    end

    // Setup writes toward the controller, data bytes excluded
    always @(negedge rst) begin
        if (sdc_req.wr && sdc_req.addr != `SDC_DATA)
            addr_log.push_back({sdc_req.addr, sdc_req.wdata});
    end

    task automatic finish_run();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic abort_run(input string why);
        timeouts++;
        $display("Timeout: %s", why);
        finish_run();
    endtask

    // ==============================
    // APB master
    // ==============================
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input word_t wdata,
                            input logic [1:0] strb, output word_t rdata, output logic err);
        int n;
        @(posedge rst);
        #1;
        apb_req.psel    = 1'b1;         // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        apb_req.pstrb   = strb;
        @(posedge rst);
        #1;
        apb_req.penable = 1'b1;
        #2;                             // Sample late in the cycle
        n = 0;
        while (!apb_rsp.pready && n < WAIT_LIMIT) begin
            @(posedge rst);
            #3;
            n++;
        end
        if (!apb_rsp.pready) begin
            abort_run($sformatf("APB transfer at 0x%0h never saw pready", addr));
        end else begin
            rdata = apb_rsp.prdata;
            err   = apb_rsp.pslverr;
            @(posedge rst);
            #1;
            apb_req.psel    = 1'b0;
            apb_req.penable = 1'b0;
        end
    endtask

    task automatic apb_write(input logic [11:0] addr, input word_t wdata,
                             input logic [1:0] strb, output logic err);
        word_t unused;
        apb_xfer(1'b1, addr, wdata, strb, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output word_t rdata, output logic err);
        apb_xfer(1'b0, addr, 16'h0000, 2'b00, rdata, err);
    endtask

    task automatic wait_idle();
        word_t st;
        logic  err;
        int    n;
        n  = 0;
        st = 16'h0001;
        while (st[0] && n < POLL_LIMIT) begin
            apb_read(A_STATUS, st, err);
            n++;
        end
        if (st[0]) abort_run("block transfer never cleared busy");
        else queue_check("status.block_busy", st[8+`ST_BLOCK_BUSY], 0);
    endtask

    task automatic load_lba(input lba_t lba);
        logic err;
        apb_write(A_LBA_HI, {8'h00, lba[23:16]}, 2'b11, err);
        apb_write(A_LBA_LO, lba[15:0], 2'b11, err);
    endtask

    // Three address bytes low first, then the direction byte
    task automatic check_addr_phase(input lba_t lba, input logic dir);
        logic [10:0] want [4];
        want[0] = {`SDC_LBA0, lba[7:0]};
        want[1] = {`SDC_LBA0 + 3'd1, lba[15:8]};
        want[2] = {`SDC_LBA0 + 3'd2, lba[23:16]};
        want[3] = {`SDC_CTRL, 7'b0, dir};
        queue_check("sdc_req setup writes", addr_log.size(), 4);
        for (int i = 0; i < 4 && i < addr_log.size(); i++)
            queue_check($sformatf("sdc_req write %0d", i), addr_log[i], want[i]);
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial begin : stimulus
        lba_t       lba;
        word_t      rd;
        word_t      wd;
        word_t      shadow [0:`SD_BUF_DEPTH-1];  // Expected buffer contents
        logic [1:0] strb;
        logic       err;
        int         n;
        int         w;

        clk     = 1'b1;
        apb_req = '0;
        repeat (4) @(posedge rst);
        #1;
        clk = 1'b0;

        // Quiet after reset
        repeat (6) begin
            @(negedge rst);
            queue_check("sdc_req.wr", sdc_req.wr, 0);
            queue_check("sdc_req.rd", sdc_req.rd, 0);
            queue_check("apb_rsp.pready", apb_rsp.pready, 1);
            queue_check("apb_rsp.pslverr", apb_rsp.pslverr, 0);
        end
        apb_read(A_STATUS, rd, err);
        queue_check("status.busy", rd[0], 0);

        // Block address readback
        lba = lba_t'($random(seed));
        load_lba(lba);
        apb_read(A_LBA_HI, rd, err);
        queue_check("lba_hi", rd, {8'h00, lba[23:16]});
        apb_read(A_LBA_LO, rd, err);
        queue_check("lba_lo", rd, lba[15:0]);

        // Byte strobes on the buffer window
        for (n = 0; n < 8; n++) begin
            w         = $random(seed) & 8'hFF;
            shadow[w] = word_t'($random(seed));
            apb_write(buf_addr(w), shadow[w], 2'b11, err);
            wd   = word_t'($random(seed));
            strb = n[0] ? 2'b01 : 2'b10;
            apb_write(buf_addr(w), wd, strb, err);
            shadow[w] = merge_word(shadow[w], wd, strb);
            apb_read(buf_addr(w), rd, err);
            queue_check($sformatf("buffer[%0d]", w), rd, shadow[w]);
            queue_check("apb_rsp.pslverr", err, 0);
        end

        // Read block, with a new lba, a second command and buffer accesses while busy
        lba = lba_t'($random(seed));
        for (n = 0; n < `SD_SECTOR_BYTES; n++)
            u_card.sector_mem[n] = pattern_byte(lba, n);
        load_lba(lba);
        addr_log.delete();
        apb_write(A_CMD, 16'h0001, 2'b11, err);
        apb_write(A_LBA_LO, ~lba[15:0], 2'b11, err);
        apb_write(A_CMD, 16'h0002, 2'b11, err);     // Ignored while busy
        apb_read(A_CMD, rd, err);
        queue_check("cmd", rd, 16'h0001);           // Accepted read command kept
        apb_read(buf_addr(3), rd, err);
        queue_check("apb_rsp.pslverr", err, 1);
        apb_write(buf_addr(3), 16'hDEAD, 2'b11, err);
        queue_check("apb_rsp.pslverr", err, 1);
        wait_idle();
        for (n = 0; n < `SD_BUF_DEPTH; n++) begin
            apb_read(buf_addr(n), rd, err);
            queue_check($sformatf("buffer[%0d]", n), rd,
                        {pattern_byte(lba, 2*n), pattern_byte(lba, 2*n+1)});
        end
        check_addr_phase(lba, 1'b0);                // No second block started

        // Write block from random buffer data
        lba = lba_t'($random(seed));
        for (n = 0; n < `SD_BUF_DEPTH; n++) begin
            shadow[n] = word_t'($random(seed));
            apb_write(buf_addr(n), shadow[n], 2'b11, err);
        end
        load_lba(lba);
        addr_log.delete();
        apb_write(A_CMD, 16'h0002, 2'b11, err);
        apb_write(buf_addr(0), ~shadow[0], 2'b11, err);
        queue_check("apb_rsp.pslverr", err, 1);
        wait_idle();
        check_addr_phase(lba, 1'b1);
        for (n = 0; n < `SD_SECTOR_BYTES; n++)
            queue_check($sformatf("card byte %0d", n), u_card.wr_record[n],
                        n[0] ? shadow[n/2][7:0] : shadow[n/2][15:8]);
        apb_read(buf_addr(0), rd, err);
        queue_check("buffer[0]", rd, shadow[0]);

        // Let the compare process catch up
        n = 0;
        while (chk_q.size() > 0 && n < 8) begin
            @(posedge rst);
            #1;
            n++;
        end
        if (chk_q.size() > 0) abort_run("check queue never drained");
        else finish_run();
    end

endmodule

// ==== sd_host_top.f ====
+incdir+verilog
verilog/sd_host_pkg.sv
verilog/sd_host_regs.sv
verilog/sector_buffer.sv
verilog/sd_block_seq.sv
verilog/sd_host_top.sv
tests/sd_card_model.sv
tests/tb_sd_host.sv

// ==== Bender.yml ====
package:
  name: sd_host

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sd_host_pkg.sv
      - verilog/sd_host_regs.sv
      - verilog/sector_buffer.sv
      - verilog/sd_block_seq.sv
      - verilog/sd_host_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/sd_card_model.sv
      - tests/tb_sd_host.sv
